//--- vlog.f
common/face_image_pkg.sv
common/face_bus_pkg.sv
detect/block_integrator.sv
detect/haar_classifier.sv
hw/result_port.sv
hw/face_detect_top.sv
test/face_detect_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --timing
TOP       = face_detect_tb
RTL_TOP   = face_detect_top
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

//--- test/face_detect_tb.sv
module face_detect_tb
  import face_image_pkg::*, face_bus_pkg::*;
();

  localparam int FRAME_WIDTH  = 16;
  localparam int FRAME_HEIGHT = 8;
  localparam int BLOCK_SIZE   = 4;
  localparam int T_BRIGHT     = 800;
  localparam int T_EDGE       = 400;
  localparam int FIFO_DEPTH   = 8;
  localparam int BLOCKS_X     = FRAME_WIDTH / BLOCK_SIZE;
  localparam int BLOCKS_Y     = FRAME_HEIGHT / BLOCK_SIZE;
  localparam int NUM_FRAMES   = 5;
  localparam int CLK_PERIOD   = 8;
  localparam int ACK_LIMIT    = 16;
  localparam int WATCHDOG_CYCLES = NUM_FRAMES * FRAME_WIDTH * FRAME_HEIGHT * 40;

  // One base brightness per block in raster block order, row 0 first
  typedef struct packed {
    logic [0:7][7:0] base;
    logic            drain;
    logic            stall;
  } frame_stim_t;

  frame_stim_t stim [NUM_FRAMES] = '{
    '{base: {8'd10, 8'd200, 8'd0, 8'd100, 8'd100, 8'd60, 8'd40, 8'd200},
      drain: 1'b1, stall: 1'b0},
    '{base: {8'd0, 8'd0, 8'd0, 8'd0, 8'd100, 8'd120, 8'd150, 8'd200},
      drain: 1'b0, stall: 1'b0},
    '{base: {8'd3, 8'd1, 8'd2, 8'd0, 8'd110, 8'd130, 8'd160, 8'd190},
      drain: 1'b1, stall: 1'b1},
    '{base: {8'd5, 8'd5, 8'd5, 8'd5, 8'd40, 8'd45, 8'd30, 8'd20},
      drain: 1'b1, stall: 1'b0},
    '{base: {8'd200, 8'd200, 8'd200, 8'd20, 8'd220, 8'd215, 8'd210, 8'd252},
      drain: 1'b1, stall: 1'b0}
  };

  logic    clk;
  logic    reset;
  pixel_t  pixel;
  logic    pixel_valid;
  logic    pixel_ready;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;

  pixel_t      frame_pix [FRAME_HEIGHT][FRAME_WIDTH];
  int          block_sum [BLOCKS_Y][BLOCKS_X];
  det_result_t expq [$];
  int          frames_done;
  logic        stall_seen;

  face_detect_top #(
    .FRAME_WIDTH  (FRAME_WIDTH),
    .FRAME_HEIGHT (FRAME_HEIGHT),
    .BLOCK_SIZE   (BLOCK_SIZE),
    .T_BRIGHT     (T_BRIGHT),
    .T_EDGE       (T_EDGE),
    .FIFO_DEPTH   (FIFO_DEPTH)
  ) i_dut (
    .clk           (clk),
    .reset         (reset),
    .i_pixel       (pixel),
    .i_pixel_valid (pixel_valid),
    .o_pixel_ready (pixel_ready),
    .i_wb          (wb_req),
    .o_wb          (wb_rsp)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles before all frames were checked",
             WATCHDOG_CYCLES);
    $display("sim failed");
    $fatal(1, "timeout");
  end

  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_count(input string name, input coord_t exp, input coord_t got);
    if (got !== exp)
    begin
      $display("ERROR time=%0t %s expected=%0d actual=%0d", $time, name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_ack(input string name, input int exp, input int got);
    if (got != exp)
    begin
      $display("ERROR time=%0t %s expected=%0d actual=%0d", $time, name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp)
    begin
      $display("ERROR time=%0t %s expected=%0b actual=%0b", $time, name, exp, got);
      abort_run();
    end
  endtask

  // Data word holds valid in bit 16, by in 15:8 and bx in 7:0
  task automatic check_result(input string name, input det_result_t exp,
                              input logic exp_valid, input wb_dat_t dat);
    det_result_t got;
    got.bx        = dat[7:0];
    got.by        = dat[15:8];
    got.frame_end = 1'b0;
    if (dat[16] !== exp_valid)
    begin
      $display("ERROR time=%0t %s.valid expected=%0b actual=%0b",
               $time, name, exp_valid, dat[16]);
      abort_run();
    end
    else if (got.bx !== exp.bx || got.by !== exp.by || dat[31:17] !== '0)
    begin
      $display("ERROR time=%0t %s bx/by expected=%0d/%0d actual=%0d/%0d upper=%0h",
               $time, name, exp.bx, exp.by, got.bx, got.by, dat[31:17]);
      abort_run();
    end
  endtask

  // Holds stb for hold cycles past the ack and counts every ack seen
  task automatic wb_read(input wb_adr_t adr, input int hold, output wb_dat_t dat);
    int waited;
    int acks;
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr};
    waited = 0;
    @(negedge clk);
    while (!wb_rsp.ack)
    begin
      waited++;
      if (waited > ACK_LIMIT)
      begin
        $display("No Wishbone ack within %0d cycles of a read at address %0d",
                 ACK_LIMIT, adr);
        abort_run();
      end
      @(negedge clk);
    end
    dat  = wb_rsp.dat;
    acks = 1;
    repeat (hold)
    begin
      @(negedge clk);
      if (wb_rsp.ack)
      begin
        acks++;
      end
    end
    @(posedge clk);
    wb_req <= '0;
    check_ack("o_wb.ack pulses per read", 1, acks);
  endtask

  task automatic read_status(output coord_t cnt, output coord_t frm);
    wb_dat_t dat;
    wb_read(ADR_STATUS, 0, dat);
    cnt = dat[7:0];
    frm = dat[15:8];
  endtask

  task automatic pop_expected();
    wb_dat_t     dat;
    det_result_t exp;
    if (expq.size() == 0)
    begin
      $display("FIFO reports a result that the model does not expect");
      abort_run();
    end
    else
    begin
      exp = expq.pop_front();
      wb_read(ADR_RESULT, 3, dat);
      check_result("popped result", exp, 1'b1, dat);
    end
  endtask

  task automatic drain_fifo(input logic at_stall);
    coord_t      cnt;
    coord_t      frm;
    wb_dat_t     dat;
    det_result_t none;
    none = '0;
    read_status(cnt, frm);
    check_count("status frame counter", coord_t'(frames_done), frm);
    if (at_stall)
    begin
      // Ready drops with one free entry left
      check_count("status fifo count at stall", coord_t'(FIFO_DEPTH - 1), cnt);
    end
    else
    begin
      check_count("status fifo count", coord_t'(expq.size()), cnt);
    end
    for (int i = 0; i < int'(cnt); i++)
    begin
      pop_expected();
    end
    wb_read(ADR_RESULT, 2, dat);
    check_result("empty result read", none, 1'b0, dat);
    read_status(cnt, frm);
    check_count("status fifo count after drain", 8'd0, cnt);
  endtask

  // Noisy pixels for one frame, plus the expected candidates
  task automatic prepare_frame(input frame_stim_t s);
    int          base;
    int          noise;
    int          sum;
    int          above;
    det_result_t cand;
    foreach (block_sum[by, bx])
    begin
      block_sum[by][bx] = 0;
    end
    for (int y = 0; y < FRAME_HEIGHT; y++)
    begin
      for (int x = 0; x < FRAME_WIDTH; x++)
      begin
        base  = int'(s.base[(y / BLOCK_SIZE) * BLOCKS_X + x / BLOCK_SIZE]);
        noise = int'($urandom % 4);
        frame_pix[y][x] = pixel_t'(base + noise);
        block_sum[y / BLOCK_SIZE][x / BLOCK_SIZE] += int'(frame_pix[y][x]);
      end
    end
    for (int by = 1; by < BLOCKS_Y; by++)
    begin
      for (int bx = 0; bx < BLOCKS_X; bx++)
      begin
        sum   = block_sum[by][bx];
        above = block_sum[by - 1][bx];
        if (sum >= T_BRIGHT && sum - above >= T_EDGE)
        begin
          cand.bx        = coord_t'(bx);
          cand.by        = coord_t'(by);
          cand.frame_end = 1'b0;
          expq.push_back(cand);
        end
      end
    end
  endtask

  // Returns once the pixel is sure to be taken at the next rising edge
  task automatic send_pixel(input pixel_t p);
    @(posedge clk);
    pixel       <= p;
    pixel_valid <= 1'b1;
    @(negedge clk);
    while (!pixel_ready)
    begin
      stall_seen = 1'b1;
      @(posedge clk);
      pixel_valid <= 1'b0;
      drain_fifo(1'b1);
      @(posedge clk);
      pixel_valid <= 1'b1;
      @(negedge clk);
    end
  endtask

  task automatic send_frame(input frame_stim_t s);
    coord_t cnt;
    coord_t frm;
    stall_seen = 1'b0;
    prepare_frame(s);
    for (int y = 0; y < FRAME_HEIGHT; y++)
    begin
      for (int x = 0; x < FRAME_WIDTH; x++)
      begin
        send_pixel(frame_pix[y][x]);
      end
    end
    @(posedge clk);
    pixel_valid <= 1'b0;
    // Last block reaches the FIFO and frame counter within 3 cycles
    repeat (3) @(posedge clk);
    frames_done++;
    check_flag("o_pixel_ready dropped during frame", s.stall, stall_seen);
    if (s.drain)
    begin
      drain_fifo(1'b0);
    end
    else
    begin
      read_status(cnt, frm);
      check_count("status frame counter", coord_t'(frames_done), frm);
      check_count("status fifo count", coord_t'(expq.size()), cnt);
    end
  endtask

  initial
  begin
    wb_dat_t     dat;
    coord_t      cnt;
    coord_t      frm;
    det_result_t none;
    reset       = 1'b1;
    pixel       = '0;
    pixel_valid = 1'b0;
    wb_req      = '0;
    frames_done = 0;
    stall_seen  = 1'b0;
    none        = '0;
    void'($urandom(32'hb39585ed));
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_flag("o_pixel_ready after reset", 1'b1, pixel_ready);
    check_flag("o_wb.ack after reset", 1'b0, wb_rsp.ack);
    read_status(cnt, frm);
    check_count("status fifo count after reset", 8'd0, cnt);
    check_count("status frame counter after reset", 8'd0, frm);
    wb_read(ADR_RESULT, 1, dat);
    check_result("result after reset", none, 1'b0, dat);
    for (int f = 0; f < NUM_FRAMES; f++)
    begin
      send_frame(stim[f]);
    end
    if (expq.size() != 0)
    begin
      $display("%0d expected results were never read from the FIFO", expq.size());
      abort_run();
    end
    else
    begin
      $display("sim passed");
    end
    $finish;
  end

endmodule

//--- hw/face_detect_top.sv
module face_detect_top
  import face_image_pkg::*, face_bus_pkg::*;
#(
  parameter int FRAME_WIDTH  = 16,
  parameter int FRAME_HEIGHT = 8,
  parameter int BLOCK_SIZE   = 4,
  parameter int T_BRIGHT     = 800,
  parameter int T_EDGE       = 400,
  parameter int FIFO_DEPTH   = 8
)
(
  input  logic    clk,
  input  logic    reset,
  input  pixel_t  i_pixel,
  input  logic    i_pixel_valid,
  output logic    o_pixel_ready,
  input  wb_req_t i_wb,
  output wb_rsp_t o_wb
);

  localparam int BLOCKS_PER_ROW = FRAME_WIDTH / BLOCK_SIZE;

  logic        pixel_accept;
  block_beat_t block;
  det_result_t result;
  logic        result_write;
  logic        result_pass;

  assign pixel_accept = i_pixel_valid && o_pixel_ready;

  block_integrator #(
    .FRAME_WIDTH  (FRAME_WIDTH),
    .FRAME_HEIGHT (FRAME_HEIGHT),
    .BLOCK_SIZE   (BLOCK_SIZE)
  ) u_integrator (
    .clk            (clk),
    .reset          (reset),
    .i_pixel        (i_pixel),
    .i_pixel_accept (pixel_accept),
    .o_block        (block)
  );

  haar_classifier #(
    .BLOCKS_PER_ROW (BLOCKS_PER_ROW),
    .T_BRIGHT       (T_BRIGHT),
    .T_EDGE         (T_EDGE)
  ) u_classifier (
    .clk            (clk),
    .reset          (reset),
    .i_block        (block),
    .o_result       (result),
    .o_result_write (result_write),
    .o_result_pass  (result_pass)
  );

  result_port #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_result (
    .clk            (clk),
    .reset          (reset),
    .i_result       (result),
    .i_result_write (result_write),
    .i_result_pass  (result_pass),
    .i_wb           (i_wb),
    .o_wb           (o_wb),
    .o_pixel_ready  (o_pixel_ready)
  );

endmodule

//--- hw/result_port.sv
module result_port
  import face_image_pkg::*, face_bus_pkg::*;
#(
  parameter int FIFO_DEPTH = 8
)
(
  input  logic        clk,
  input  logic        reset,
  input  det_result_t i_result,
  input  logic        i_result_write,
  input  logic        i_result_pass,
  input  wb_req_t     i_wb,
  output wb_rsp_t     o_wb,
  output logic        o_pixel_ready
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // Layout matches bits 15 to 0 of the result word
  typedef struct packed {
    coord_t by;
    coord_t bx;
  } fifo_entry_t;

  typedef enum logic [1:0] {
    WB_IDLE,
    WB_ACK,
    WB_HOLD
  } wb_state_t;

  fifo_entry_t      mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [7:0]       frame_cnt;

  wb_state_t state;
  wb_state_t state_next;
  wb_dat_t   dat_q;
  wb_dat_t   read_word;

  logic full;
  logic empty;
  logic push;
  logic pop;
  logic req;
  logic start;

  assign full  = count == CNT_W'(FIFO_DEPTH);
  assign empty = count == '0;
  assign push  = i_result_write && i_result_pass && !full;

  assign req   = i_wb.cyc && i_wb.stb;
  assign start = (state == WB_IDLE) && req;
  assign pop   = start && !i_wb.we && (i_wb.adr == ADR_RESULT) && !empty;

  // Keep room for a block still in the pipeline
  assign o_pixel_ready = count <= CNT_W'(FIFO_DEPTH - 2);

  always_comb
  begin
    read_word = '0;
    if (!i_wb.we)
    begin
      case (i_wb.adr)
        // Bit 16 flags a stored candidate
        ADR_RESULT: read_word = empty ? '0 : {15'b0, 1'b1, mem[rd_ptr]};
        ADR_STATUS: read_word = {16'b0, frame_cnt, 8'(count)};
        default:    read_word = '0;
      endcase
    end
  end

  // Ack once per request and wait for the master to drop stb
  always_comb
  begin
    case (state)
      WB_IDLE: state_next = req ? WB_ACK : WB_IDLE;
      WB_ACK:  state_next = req ? WB_HOLD : WB_IDLE;
      WB_HOLD: state_next = req ? WB_HOLD : WB_IDLE;
      default: state_next = WB_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= '{by: i_result.by, bx: i_result.bx};
    end
    if (start)
    begin
      dat_q <= read_word;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      frame_cnt <= '0;
      state     <= WB_IDLE;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop)
      begin
        count <= count + 1'b1;
      end
      else if (pop && !push)
      begin
        count <= count - 1'b1;
      end
      if (i_result_write && i_result.frame_end)
      begin
        frame_cnt <= frame_cnt + 1'b1;
      end
      state <= state_next;
    end
  end

  assign o_wb.ack = state == WB_ACK;
  assign o_wb.dat = dat_q;

endmodule

//--- detect/haar_classifier.sv
module haar_classifier
  import face_image_pkg::*, face_bus_pkg::*;
#(
  parameter int BLOCKS_PER_ROW = 4,
  parameter int T_BRIGHT       = 800,
  parameter int T_EDGE         = 400
)
(
  input  logic        clk,
  input  logic        reset,
  input  block_beat_t i_block,
  output det_result_t o_result,
  output logic        o_result_write,
  output logic        o_result_pass
);

  localparam int COL_W = (BLOCKS_PER_ROW > 1) ? $clog2(BLOCKS_PER_ROW) : 1;
  localparam int SUM_W = $bits(block_sum_t);

  // One extra bit so the difference of two sums keeps its sign
  typedef logic signed [SUM_W:0] contrast_t;

  localparam block_sum_t BRIGHT_MIN = block_sum_t'(T_BRIGHT);
  localparam contrast_t  EDGE_MIN   = contrast_t'(T_EDGE);

  // Sums of the block row above, indexed by bx
  block_sum_t row_buf [BLOCKS_PER_ROW];

  logic [COL_W-1:0] col;
  block_sum_t       above;
  contrast_t        contrast;
  logic             bright_ok;
  logic             edge_ok;
  logic             pass;

  assign col      = i_block.bx[COL_W-1:0];
  assign above    = row_buf[col];
  assign contrast = contrast_t'(i_block.sum) - contrast_t'(above);

  // Stage 1 brightness, stage 2 vertical edge against the block above
  assign bright_ok = i_block.sum >= BRIGHT_MIN;
  assign edge_ok   = contrast >= EDGE_MIN;
  // Top block row has nothing above it
  assign pass      = (i_block.by != '0) && bright_ok && edge_ok;

  always_ff @(posedge clk)
  begin
    if (i_block.valid)
    begin
      row_buf[col] <= i_block.sum;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      o_result_write <= 1'b0;
      o_result_pass  <= 1'b0;
    end
    else
    begin
      // Frame end always goes out so the port can count frames
      o_result_write <= i_block.valid && (pass || i_block.frame_end);
      o_result_pass  <= i_block.valid && pass;
    end
    if (i_block.valid)
    begin
      o_result.bx        <= i_block.bx;
      o_result.by        <= i_block.by;
      o_result.frame_end <= i_block.frame_end;
    end
  end

endmodule

//--- detect/block_integrator.sv
module block_integrator
  import face_image_pkg::*;
#(
  parameter int FRAME_WIDTH  = 16,
  parameter int FRAME_HEIGHT = 8,
  parameter int BLOCK_SIZE   = 4
)
(
  input  logic        clk,
  input  logic        reset,
  input  pixel_t      i_pixel,
  input  logic        i_pixel_accept,
  output block_beat_t o_block
);

  localparam int BLOCKS_X = FRAME_WIDTH / BLOCK_SIZE;
  localparam int COL_W    = (BLOCKS_X > 1) ? $clog2(BLOCKS_X) : 1;

  localparam coord_t LAST_X     = coord_t'(FRAME_WIDTH - 1);
  localparam coord_t LAST_Y     = coord_t'(FRAME_HEIGHT - 1);
  localparam coord_t LAST_LOCAL = coord_t'(BLOCK_SIZE - 1);

  // Raster position of the incoming pixel
  coord_t x;
  coord_t y;

  coord_t lx;
  coord_t ly;
  coord_t bx;
  coord_t by;
  logic [COL_W-1:0] col;

  // One running sum per block column across the frame
  block_sum_t acc [BLOCKS_X];
  block_sum_t acc_next;
  logic       block_done;
  logic       frame_done;

  assign lx  = coord_t'(x % BLOCK_SIZE);
  assign ly  = coord_t'(y % BLOCK_SIZE);
  assign bx  = coord_t'(x / BLOCK_SIZE);
  assign by  = coord_t'(y / BLOCK_SIZE);
  assign col = bx[COL_W-1:0];

  assign acc_next   = acc[col] + block_sum_t'(i_pixel);
  assign block_done = i_pixel_accept && (lx == LAST_LOCAL) && (ly == LAST_LOCAL);
  assign frame_done = (x == LAST_X) && (y == LAST_Y);

  // Coordinate tracker and column accumulators
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      x <= '0;
      y <= '0;
      for (int i = 0; i < BLOCKS_X; i++)
      begin
        acc[i] <= '0;
      end
    end
    else if (i_pixel_accept)
    begin
      if (x == LAST_X)
      begin
        x <= '0;
        y <= (y == LAST_Y) ? '0 : y + 1'b1;
      end
      else
      begin
        x <= x + 1'b1;
      end
      // Bottom right pixel closes the block, start the next block row clean
      acc[col] <= block_done ? '0 : acc_next;
    end
  end

  // Block beat, one cycle after the closing pixel
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      o_block.valid <= 1'b0;
    end
    else
    begin
      o_block.valid <= block_done;
    end
    if (block_done)
    begin
      o_block.bx        <= bx;
      o_block.by        <= by;
      o_block.sum       <= acc_next;
      o_block.frame_end <= frame_done;
    end
  end

endmodule

//--- common/face_bus_pkg.sv
package face_bus_pkg;

  import face_image_pkg::*;

  // Block coordinates of a detection, frame_end marks the last block of a frame
  typedef struct packed {
    coord_t bx;
    coord_t by;
    logic   frame_end;
  } det_result_t;

  typedef logic [1:0]  wb_adr_t;
  typedef logic [31:0] wb_dat_t;

  // Read-only slave, so no data-in or byte selects
  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
  } wb_req_t;

  typedef struct packed {
    logic    ack;
    wb_dat_t dat;
  } wb_rsp_t;

  // Register map
  localparam wb_adr_t ADR_RESULT = 2'd0;
  localparam wb_adr_t ADR_STATUS = 2'd1;

endpackage

//--- common/face_image_pkg.sv
package face_image_pkg;

  // Grey pixel from the camera stream
  typedef logic [7:0] pixel_t;

  // Pixel or block position, x and y share one type
  typedef logic [7:0] coord_t;

  // Sum of one 4 by 4 block of 8-bit pixels, 16 * 255 fits in 12 bits
  typedef logic [11:0] block_sum_t;

  // One finished block, as handed from the integrator to the classifier
  typedef struct packed {
    logic       valid;
    coord_t     bx;
    coord_t     by;
    block_sum_t sum;
    logic       frame_end;
  } block_beat_t;

endpackage
